//--- hw/mem_cfg_pkg.sv
`default_nettype none

package mem_cfg_pkg;

	// Array geometry
	localparam int WORD_W      = 16;
	localparam int ADDR_W      = 8;
	localparam int MEM_DEPTH   = 256;          // 2**ADDR_W words
	localparam int BLOCK_WORDS = 4;            // Words returned by one read

	// Access latency
	localparam int MEM_STALL_COUNT = 4;        // Cycles from request pickup to access
	localparam int STALL_W         = 3;        // Must hold MEM_STALL_COUNT

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// Word 0 in the low bits is the word at the request address,
	// the higher words follow with the address wrapping at the top
	typedef logic [BLOCK_WORDS-1:0][WORD_W-1:0] block_t;

endpackage

`default_nettype wire

//--- hw/mem_msg_pkg.sv
`default_nettype none

package mem_msg_pkg;

	import mem_cfg_pkg::*;

	// Request as it waits in the request slot
	typedef struct packed {
		logic  write;       // 1 = store wdata, 0 = block read
		addr_t addr;        // Word address
		word_t wdata;       // Only meaningful for writes
	} mem_req_t;

	// Response as it waits in the response slot
	typedef struct packed {
		logic   write;      // Set for a write acknowledge
		block_t data;       // Read block, zero on an acknowledge
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- hw/mem_port_if.sv
`default_nettype none

interface mem_port_if
	import mem_cfg_pkg::*;
();

	logic   strobe;     // Single-cycle access pulse
	logic   write;      // Store when set, block read otherwise
	addr_t  addr;
	word_t  wdata;
	block_t rdata;      // Held until the next read on this port

	modport master (
		output strobe, write, addr, wdata,
		input  rdata
	);

	modport target (
		input  strobe, write, addr, wdata,
		output rdata
	);

endinterface

`default_nettype wire

//--- hw/req_slot.sv
`default_nettype none

module req_slot #(
	parameter type payload_t = logic
) (
	input  wire logic     clk,
	input  wire logic     reset_n,

	input  wire logic     in_valid,
	output logic          in_ready,
	input  wire payload_t in_data,

	output logic          out_valid,
	input  wire logic     out_ready,
	output payload_t      out_data
);

	logic     full;
	payload_t data_q;
	logic     load;

	// Accept when empty or when the held entry leaves on this edge
	assign in_ready = !full || out_ready;
	assign load     = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			full <= 1'b0;
		end else if (load) begin
			full <= 1'b1;      // Refill, possibly while draining
		end else if (out_ready) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			data_q <= in_data;
		end
	end

	assign out_valid = full;
	assign out_data  = data_q;

endmodule

`default_nettype wire

//--- hw/stall_timer.sv
`default_nettype none

module stall_timer
	import mem_cfg_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset_n,
	input  wire logic start,      // Loads the stall count
	output logic      done        // One cycle, sampled MEM_STALL_COUNT edges after start
);

	logic [STALL_W-1:0] count;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			count <= '0;
		end else if (start) begin
			count <= STALL_W'(MEM_STALL_COUNT);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Last cycle before the count runs out
	assign done = (count == STALL_W'(1));

endmodule

`default_nettype wire

//--- hw/port_fsm.sv
`default_nettype none

module port_fsm
	import mem_msg_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     reset_n,

	// From the request slot
	input  wire logic     req_valid,
	output logic          req_ready,
	input  wire mem_req_t req,

	// To the response slot
	output logic          rsp_valid,
	input  wire logic     rsp_ready,
	output mem_rsp_t      rsp,

	// Stall timer
	output logic          start,
	input  wire logic     done,

	mem_port_if.master    mem
);

	typedef enum logic [1:0] {
		idle,
		stall,
		access,
		respond
	} state_t;

	state_t   state;
	state_t   state_next;
	mem_req_t req_q;        // Request in service
	logic     take;
	logic     fire;

	assign take      = (state == idle) && req_valid;
	assign req_ready = (state == idle);
	assign start     = take;              // Timer runs from the pickup edge

	// Access only when the response slot can take the result
	assign fire = rsp_ready && (((state == stall) && done) || (state == access));

	assign mem.strobe = fire;
	assign mem.write  = req_q.write;
	assign mem.addr   = req_q.addr;
	assign mem.wdata  = req_q.wdata;

	assign rsp_valid = (state == respond);
	assign rsp       = '{write: req_q.write, data: req_q.write ? '0 : mem.rdata};

	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				if (req_valid) begin
					state_next = stall;
				end
			end
			stall: begin
				if (done) begin
					state_next = rsp_ready ? respond : access;
				end
			end
			access: begin
				if (rsp_ready) begin
					state_next = respond;   // Strobe issued this cycle
				end
			end
			respond: begin
				if (rsp_ready) begin
					state_next = idle;
				end
			end
			default: state_next = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= idle;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			req_q <= req;
		end
	end

endmodule

`default_nettype wire

//--- hw/block_ram.sv
`default_nettype none

module block_ram
	import mem_cfg_pkg::*;
(
	input  wire logic  clk,
	mem_port_if.target ip,      // Instruction port
	mem_port_if.target dp       // Data port
);

	word_t mem [MEM_DEPTH];

	// Both ports share one process so the array has a single writer.
	// Reads use the contents from before this edge, and the data
	// port write comes last so it wins an address collision.
	always_ff @(posedge clk) begin
		if (ip.strobe) begin
			if (ip.write) begin
				mem[ip.addr] <= ip.wdata;
			end else begin
				for (int k = 0; k < BLOCK_WORDS; k++) begin
					ip.rdata[k] <= mem[ip.addr + addr_t'(k)];   // Wraps at the top
				end
			end
		end

		if (dp.strobe) begin
			if (dp.write) begin
				mem[dp.addr] <= dp.wdata;
			end else begin
				for (int k = 0; k < BLOCK_WORDS; k++) begin
					dp.rdata[k] <= mem[dp.addr + addr_t'(k)];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/mem_top.sv
`default_nettype none

module mem_top
	import mem_cfg_pkg::*;
	import mem_msg_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   reset_n,

	// Instruction port
	input  wire logic   i_req_valid,
	output logic        i_req_ready,
	input  wire logic   i_req_write,
	input  wire addr_t  i_req_addr,
	input  wire word_t  i_req_wdata,
	output logic        i_rsp_valid,
	input  wire logic   i_rsp_ready,
	output logic        i_rsp_write,
	output block_t      i_rsp_data,

	// Data port
	input  wire logic   d_req_valid,
	output logic        d_req_ready,
	input  wire logic   d_req_write,
	input  wire addr_t  d_req_addr,
	input  wire word_t  d_req_wdata,
	output logic        d_rsp_valid,
	input  wire logic   d_rsp_ready,
	output logic        d_rsp_write,
	output block_t      d_rsp_data
);

	mem_req_t i_req;        // Slot to FSM
	mem_req_t d_req;
	logic     i_req_vld;
	logic     d_req_vld;
	logic     i_req_rdy;
	logic     d_req_rdy;
	mem_rsp_t i_rsp;        // FSM to slot
	mem_rsp_t d_rsp;
	logic     i_rsp_vld;
	logic     d_rsp_vld;
	logic     i_rsp_rdy;
	logic     d_rsp_rdy;
	mem_rsp_t i_rsp_out;    // Slot to top ports
	mem_rsp_t d_rsp_out;
	logic     i_start;
	logic     d_start;
	logic     i_done;
	logic     d_done;

	mem_port_if i_mem ();
	mem_port_if d_mem ();

	assign i_rsp_write = i_rsp_out.write;
	assign i_rsp_data  = i_rsp_out.data;
	assign d_rsp_write = d_rsp_out.write;
	assign d_rsp_data  = d_rsp_out.data;

	// Instruction port
	req_slot #(.payload_t(mem_req_t)) i_req_slot_i (
		.clk, .reset_n,
		.in_valid (i_req_valid),
		.in_ready (i_req_ready),
		.in_data  (mem_req_t'{write: i_req_write, addr: i_req_addr, wdata: i_req_wdata}),
		.out_valid(i_req_vld),
		.out_ready(i_req_rdy),
		.out_data (i_req)
	);

	port_fsm i_fsm_i (
		.clk, .reset_n,
		.req_valid(i_req_vld), .req_ready(i_req_rdy), .req(i_req),
		.rsp_valid(i_rsp_vld), .rsp_ready(i_rsp_rdy), .rsp(i_rsp),
		.start(i_start), .done(i_done),
		.mem(i_mem.master)
	);

	stall_timer i_timer_i (.clk, .reset_n, .start(i_start), .done(i_done));

	req_slot #(.payload_t(mem_rsp_t)) i_rsp_slot_i (
		.clk, .reset_n,
		.in_valid (i_rsp_vld),
		.in_ready (i_rsp_rdy),
		.in_data  (i_rsp),
		.out_valid(i_rsp_valid),
		.out_ready(i_rsp_ready),
		.out_data (i_rsp_out)
	);

	// Data port
	req_slot #(.payload_t(mem_req_t)) d_req_slot_i (
		.clk, .reset_n,
		.in_valid (d_req_valid),
		.in_ready (d_req_ready),
		.in_data  (mem_req_t'{write: d_req_write, addr: d_req_addr, wdata: d_req_wdata}),
		.out_valid(d_req_vld),
		.out_ready(d_req_rdy),
		.out_data (d_req)
	);

	port_fsm d_fsm_i (
		.clk, .reset_n,
		.req_valid(d_req_vld), .req_ready(d_req_rdy), .req(d_req),
		.rsp_valid(d_rsp_vld), .rsp_ready(d_rsp_rdy), .rsp(d_rsp),
		.start(d_start), .done(d_done),
		.mem(d_mem.master)
	);

	stall_timer d_timer_i (.clk, .reset_n, .start(d_start), .done(d_done));

	req_slot #(.payload_t(mem_rsp_t)) d_rsp_slot_i (
		.clk, .reset_n,
		.in_valid (d_rsp_vld),
		.in_ready (d_rsp_rdy),
		.in_data  (d_rsp),
		.out_valid(d_rsp_valid),
		.out_ready(d_rsp_ready),
		.out_data (d_rsp_out)
	);

	// Shared array
	block_ram ram_i (
		.clk,
		.ip(i_mem.target),
		.dp(d_mem.target)
	);

endmodule

`default_nettype wire

//--- verif/mem_checker.sv
`default_nettype none

module mem_checker
	import mem_cfg_pkg::*;
	import mem_msg_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  reset_n,

	input  wire logic  i_req_valid,
	input  wire logic  i_req_ready,
	input  wire logic  i_req_write,
	input  wire addr_t i_req_addr,
	input  wire word_t i_req_wdata,
	input  wire logic  i_rsp_valid,
	input  wire logic  i_rsp_ready,
	input  wire logic  i_rsp_write,
	input  wire block_t i_rsp_data,

	input  wire logic  d_req_valid,
	input  wire logic  d_req_ready,
	input  wire logic  d_req_write,
	input  wire addr_t d_req_addr,
	input  wire word_t d_req_wdata,
	input  wire logic  d_rsp_valid,
	input  wire logic  d_rsp_ready,
	input  wire logic  d_rsp_write,
	input  wire block_t d_rsp_data,

	output int         errors,
	output int         responses,
	output int         lat_checks,
	output logic       quiet          // Nothing outstanding on either port
);

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct {
		mem_req_t req;
		int       cycle;              // Edge count at acceptance
		bit       timed;              // Accepted on an idle port
	} pend_t;

	pend_t    i_pend[$];
	pend_t    d_pend[$];
	word_t    model [MEM_DEPTH];      // Memory as seen two edges back
	int       cycle;

	// Per-port views with index 0 for the instruction port
	logic     qv [2];
	logic     qr [2];
	mem_req_t qd [2];
	logic     rv [2];
	logic     rr [2];
	logic     rw [2];
	block_t   rd [2];
	logic     vld_prev [2];
	logic     rdy_prev [2];
	logic     wr_prev [2];
	block_t   data_prev [2];

	assign qv[0] = i_req_valid;
	assign qr[0] = i_req_ready;
	assign qd[0] = mem_req_t'{write: i_req_write, addr: i_req_addr, wdata: i_req_wdata};
	assign rv[0] = i_rsp_valid;
	assign rr[0] = i_rsp_ready;
	assign rw[0] = i_rsp_write;
	assign rd[0] = i_rsp_data;
	assign qv[1] = d_req_valid;
	assign qr[1] = d_req_ready;
	assign qd[1] = mem_req_t'{write: d_req_write, addr: d_req_addr, wdata: d_req_wdata};
	assign rv[1] = d_rsp_valid;
	assign rr[1] = d_rsp_ready;
	assign rw[1] = d_rsp_write;
	assign rd[1] = d_rsp_data;

	// Expected read block, wrapping at the top of the array
	function automatic block_t ref_block(input addr_t a);
		block_t b;
		for (int k = 0; k < BLOCK_WORDS; k++) begin
			b[k] = model[addr_t'(a + k)];
		end
		return b;
	endfunction

	function automatic string port_name(input int p);
		return (p != 0) ? "d" : "i";
	endfunction

	function automatic int pend_size(input int p);
		return (p != 0) ? d_pend.size() : i_pend.size();
	endfunction

	task automatic push_pend(input int p, input pend_t e);
		if (p != 0) begin
			d_pend.push_back(e);
		end else begin
			i_pend.push_back(e);
		end
	endtask

	task automatic pop_pend(input int p, output pend_t e);
		if (p != 0) begin
			e = d_pend.pop_front();
		end else begin
			e = i_pend.pop_front();
		end
	endtask

	initial begin
		errors     = 0;
		responses  = 0;
		lat_checks = 0;
		quiet      = 1'b1;
		cycle      = 0;
	end

	// Signals read here are the values just before the edge
	always @(posedge clk) begin : check_edge
		pend_t    head;
		pend_t    entry;
		mem_req_t wreq [2];
		logic     wvalid [2];
		block_t   exp_data;
		logic     exp_wr;
		int       lat;

		if (!reset_n) begin
			i_pend.delete();
			d_pend.delete();
			for (int p = 0; p < 2; p++) begin
				vld_prev[p] = 1'b0;
				rdy_prev[p] = 1'b0;
			end
		end else begin
			cycle++;

			// A response loaded one edge back was accessed two edges back
			for (int p = 0; p < 2; p++) begin
				wvalid[p] = 1'b0;
				if (rv[p] && (!vld_prev[p] || rdy_prev[p])) begin
					if (pend_size(p) == 0) begin
						errors++;
						$display("port %s returned a response with no request outstanding",
							port_name(p));
					end else begin
						pop_pend(p, head);
						responses++;
						exp_wr   = head.req.write;
						exp_data = exp_wr ? '0 : ref_block(head.req.addr);
						if (rw[p] !== exp_wr) begin
							errors++;
							$display("mismatch %s_rsp_write: expected %h, actual %h",
								port_name(p), exp_wr, rw[p]);
						end
						if (rd[p] !== exp_data) begin
							errors++;
							$display("mismatch %s_rsp_data: expected %h, actual %h",
								port_name(p), exp_data, rd[p]);
						end
						if (exp_wr) begin
							wvalid[p] = 1'b1;
							wreq[p]   = head.req;
						end
						if (head.timed) begin
							lat = cycle - 1 - head.cycle;
							lat_checks++;
							if (lat != MEM_STALL_COUNT + 2) begin
								errors++;
								$display("mismatch %s_rsp_valid latency: expected %h, actual %h",
									port_name(p), MEM_STALL_COUNT + 2, lat);
							end
						end
					end
				end
			end

			// Reads above saw the old contents and the data port write goes last
			for (int p = 0; p < 2; p++) begin
				if (wvalid[p]) begin
					model[wreq[p].addr] = wreq[p].wdata;
				end
			end

			for (int p = 0; p < 2; p++) begin
				if (vld_prev[p] && !rdy_prev[p]) begin
					if (!rv[p]) begin
						errors++;
						$display("port %s dropped a response before its handshake",
							port_name(p));
					end else if (rd[p] !== data_prev[p] || rw[p] !== wr_prev[p]) begin
						errors++;
						$display("mismatch %s_rsp_data while stalled: expected %h, actual %h",
							port_name(p), data_prev[p], rd[p]);
					end
				end
				if (qv[p] && qr[p]) begin
					entry.req   = qd[p];
					entry.cycle = cycle;
					entry.timed = (pend_size(p) == 0) && (!rv[p] || rr[p]);
					push_pend(p, entry);
				end
				vld_prev[p]  = rv[p];
				rdy_prev[p]  = rr[p];
				wr_prev[p]   = rw[p];
				data_prev[p] = rd[p];
			end
		end
		quiet = (i_pend.size() == 0) && (d_pend.size() == 0) && !rv[0] && !rv[1];
	end

endmodule

`default_nettype wire

//--- verif/tb_mem_top.sv
`default_nettype none

module tb_mem_top
	import mem_cfg_pkg::*;
	import mem_msg_pkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RAND  = 150;                         // Random requests per port
	localparam int N_TXN   = 256 + 40 + 2 * N_RAND;
	localparam int MAX_GAP = 4;                           // Longest rsp_ready low run
	localparam int MARGIN  = 500;
	localparam int LIMIT   = N_TXN * (MEM_STALL_COUNT + 2 + MAX_GAP) + MARGIN;

	logic        clk;
	logic        reset_n;
	logic        i_req_valid;
	logic        i_req_ready;
	logic        i_req_write;
	addr_t       i_req_addr;
	word_t       i_req_wdata;
	logic        i_rsp_valid;
	logic        i_rsp_ready;
	logic        i_rsp_write;
	block_t      i_rsp_data;
	logic        d_req_valid;
	logic        d_req_ready;
	logic        d_req_write;
	addr_t       d_req_addr;
	word_t       d_req_wdata;
	logic        d_rsp_valid;
	logic        d_rsp_ready;
	logic        d_rsp_write;
	block_t      d_rsp_data;

	int          chk_errors;
	int          responses;
	int          lat_checks;
	logic        quiet;
	int          tb_errors;
	int          cycles;
	logic        rand_ready;                              // Random rsp_ready gaps on
	logic        d_hold;
	int          i_gap;
	int          d_gap;
	logic [31:0] lcg_state = 32'h381e_7e3c;

	mem_top mem_top_i (.*);

	mem_checker chk_i (
		.clk, .reset_n,
		.i_req_valid, .i_req_ready, .i_req_write, .i_req_addr, .i_req_wdata,
		.i_rsp_valid, .i_rsp_ready, .i_rsp_write, .i_rsp_data,
		.d_req_valid, .d_req_ready, .d_req_write, .d_req_addr, .d_req_wdata,
		.d_rsp_valid, .d_rsp_ready, .d_rsp_write, .d_rsp_data,
		.errors(chk_errors), .responses, .lat_checks, .quiet
	);

	always #20 clk = ~clk;

	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic word_t fill_word(input addr_t a);
		return {~a, a ^ 8'h3c};                                // Both bytes follow the address
	endfunction

	// Starts and ends a small delay after a rising edge
	task automatic send(input bit dport, input bit wr, input addr_t a, input word_t wd);
		logic ok;
		ok = 1'b0;
		if (dport) begin
			d_req_valid = 1'b1;
			d_req_write = wr;
			d_req_addr  = a;
			d_req_wdata = wd;
		end else begin
			i_req_valid = 1'b1;
			i_req_write = wr;
			i_req_addr  = a;
			i_req_wdata = wd;
		end
		while (!ok) begin
			@(negedge clk);
			ok = dport ? d_req_ready : i_req_ready;
			@(posedge clk);
			#2;
		end
		if (dport) begin
			d_req_valid = 1'b0;
		end else begin
			i_req_valid = 1'b0;
		end
	endtask

	task automatic rand_traffic(input bit dport, input int n);
		logic [31:0] r;
		for (int k = 0; k < n; k++) begin
			r = next_rand();
			send(dport, r[0], r[15:8], r[31:16]);
			if (r[3:2] != 0) begin
				repeat (r[3:2]) @(posedge clk);
				#2;
			end
		end
	endtask

	task automatic wait_quiet();
		do begin
			@(negedge clk);
		end while (!quiet);
		@(posedge clk);
		#2;
	endtask

	always @(posedge clk) begin : ready_drive
		logic [31:0] r;
		#2;
		r = next_rand();
		if (rand_ready) begin
			if (i_gap > 0) begin
				i_rsp_ready = 1'b0;
				i_gap--;
			end else begin
				i_rsp_ready = 1'b1;
				if (r[2:0] == 0) i_gap = r[5:4] + 1;
			end
			if (d_gap > 0) begin
				d_rsp_ready = 1'b0;
				d_gap--;
			end else begin
				d_rsp_ready = 1'b1;
				if (r[10:8] == 0) d_gap = r[13:12] + 1;
			end
		end else begin
			i_rsp_ready = 1'b1;
			d_rsp_ready = d_hold;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		cycles = 0;
		tb_errors = 0;
		rand_ready = 1'b0;
		d_hold = 1'b1;
		i_gap = 0;
		d_gap = 0;
		i_req_valid = 1'b0;
		i_req_write = 1'b0;
		i_req_addr = '0;
		i_req_wdata = '0;
		i_rsp_ready = 1'b1;
		d_req_valid = 1'b0;
		d_req_write = 1'b0;
		d_req_addr = '0;
		d_req_wdata = '0;
		d_rsp_ready = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		reset_n = 1'b1;
		if (!i_req_ready || !d_req_ready || i_rsp_valid || d_rsp_valid) begin
			tb_errors++;
			$display("handshake outputs are not at their reset values");
		end

		fork                                                  // Fill the whole array
			for (int a = 0; a < 128; a++) send(1'b0, 1'b1, addr_t'(a), fill_word(addr_t'(a)));
			for (int a = 128; a < 256; a++) send(1'b1, 1'b1, addr_t'(a), fill_word(addr_t'(a)));
		join
		wait_quiet();

		send(1'b1, 1'b1, 8'h40, 16'hbeef);                    // Write then read back
		send(1'b1, 1'b0, 8'h40, '0);
		wait_quiet();

		send(1'b1, 1'b1, 8'hfe, 16'ha0fe);                    // Wrap at the top
		send(1'b1, 1'b1, 8'hff, 16'ha0ff);
		send(1'b1, 1'b1, 8'h00, 16'ha000);
		send(1'b1, 1'b1, 8'h01, 16'ha001);
		send(1'b0, 1'b0, 8'hfe, '0);
		send(1'b1, 1'b0, 8'hfd, '0);
		wait_quiet();

		fork                                                  // Cross-port traffic
			for (int k = 0; k < 8; k++) send(1'b1, 1'b1, addr_t'(8'h80 + k), word_t'(16'h3000 + k));
			for (int k = 0; k < 5; k++) send(1'b0, 1'b0, addr_t'(8'h80 + k), '0);
		join
		wait_quiet();

		send(1'b0, 1'b0, 8'h22, '0);                          // Idle port, ready high
		wait_quiet();

		d_hold = 1'b0;                                        // Responses blocked
		@(posedge clk);
		#2;
		send(1'b1, 1'b0, 8'h10, '0);
		send(1'b1, 1'b1, 8'h11, 16'h5511);
		if (d_req_ready) begin
			tb_errors++;
			$display("d_req_ready still high after two requests with responses blocked");
		end
		fork
			begin
				send(1'b1, 1'b0, 8'h11, '0);
				send(1'b1, 1'b0, 8'h0f, '0);
			end
			begin
				repeat (20) @(posedge clk);
				#2;
				d_hold = 1'b1;
			end
		join
		wait_quiet();

		rand_ready = 1'b1;                                    // Random mix on both ports
		fork
			rand_traffic(1'b0, N_RAND);
			rand_traffic(1'b1, N_RAND);
		join
		wait_quiet();

		$display("errors: %0d checker, %0d testbench; responses %0d; latency checks %0d",
			chk_errors, tb_errors, responses, lat_checks);
		if (chk_errors == 0 && tb_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hw/mem_cfg_pkg.sv
hw/mem_msg_pkg.sv
hw/mem_port_if.sv
hw/req_slot.sv
hw/stall_timer.sv
hw/port_fsm.sv
hw/block_ram.sv
hw/mem_top.sv
verif/mem_checker.sv
verif/tb_mem_top.sv

//--- Bender.yml
package:
  name: mem_top

sources:
  - hw/mem_cfg_pkg.sv
  - hw/mem_msg_pkg.sv
  - hw/mem_port_if.sv
  - hw/req_slot.sv
  - hw/stall_timer.sv
  - hw/port_fsm.sv
  - hw/block_ram.sv
  - hw/mem_top.sv
  - target: test
    files:
      - verif/mem_checker.sv
      - verif/tb_mem_top.sv
